// File: src/burst_copy_pkg.sv
package burst_copy_pkg;

    localparam int DATA_WIDTH   = 16;
    localparam int BYTE_LANES   = DATA_WIDTH / 8;
    localparam int BURST_WIDTH  = 8;
    localparam int MAX_BURST    = 8;              // largest burst the intake issues.
    localparam int LENGTH_WIDTH = 16;
    localparam int FIFO_DEPTH   = 16;
    localparam int LEVEL_WIDTH  = 5;              // holds 0 .. FIFO_DEPTH.

    typedef enum logic [1:0] {
        OP_COPY,
        OP_INVERT,
        OP_SWAP_BYTES
    } copy_op_t;

    typedef enum logic [2:0] {
        READER_IDLE,
        READER_REQUEST,
        READER_RECEIVE
    } reader_state_t;

    typedef enum logic [2:0] {
        WRITER_IDLE,
        WRITER_BURST
    } writer_state_t;

    typedef enum logic [2:0] {
        INTAKE_IDLE,
        INTAKE_RUN,
        INTAKE_ACK
    } intake_state_t;

endpackage

// File: src/copy_command_intake.sv
`timescale 1ns/100ps

module copy_command_intake (
    input  logic                                  clock,
    input  logic                                  clock_sreset,
    input  logic                                  cmd_req,
    output logic                                  cmd_ack,
    input  logic [31:0]                           cmd_source,
    input  logic [31:0]                           cmd_destination,
    input  logic [burst_copy_pkg::LENGTH_WIDTH-1:0] cmd_length,
    input  burst_copy_pkg::copy_op_t              cmd_op,
    output burst_copy_pkg::copy_op_t              op,
    output logic                                  read_go,
    input  logic                                  read_busy,
    output logic [31:0]                           read_pointer,
    output logic [burst_copy_pkg::BURST_WIDTH-1:0] read_count,
    output logic                                  write_go,
    input  logic                                  write_busy,
    output logic [31:0]                           write_pointer,
    output logic [burst_copy_pkg::BURST_WIDTH-1:0] write_count,
    input  logic [burst_copy_pkg::LEVEL_WIDTH-1:0] fifo_level
);
    import burst_copy_pkg::*;

    intake_state_t             state;
    logic [LENGTH_WIDTH-1:0]   read_remaining;
    logic [LENGTH_WIDTH-1:0]   write_remaining;
    logic [BURST_WIDTH-1:0]    read_chunk;
    logic [BURST_WIDTH-1:0]    write_chunk;
    logic                      read_launch;
    logic                      write_launch;
    logic                      all_done;

    always_comb begin
        read_chunk = (read_remaining > LENGTH_WIDTH'(MAX_BURST)) ?
                     BURST_WIDTH'(MAX_BURST) : BURST_WIDTH'(read_remaining);
        write_chunk = (write_remaining > LENGTH_WIDTH'(MAX_BURST)) ?
                      BURST_WIDTH'(MAX_BURST) : BURST_WIDTH'(write_remaining);

        // room for the whole burst keeps the reader free of back-pressure.
        read_launch = (state == INTAKE_RUN) && (read_remaining != '0) &&
                      !read_busy && !read_go &&
                      (LENGTH_WIDTH'(fifo_level) + LENGTH_WIDTH'(read_chunk) <=
                       LENGTH_WIDTH'(FIFO_DEPTH));

        // write side may only trail the read side.
        write_launch = (state == INTAKE_RUN) && (write_remaining != '0) &&
                       (write_remaining > read_remaining) &&
                       !write_busy && !write_go;

        all_done = (state == INTAKE_RUN) && (read_remaining == '0) &&
                   (write_remaining == '0) && !write_busy && !write_go;
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            state <= INTAKE_IDLE;
            cmd_ack <= 1'b0;
            read_go <= 1'b0;
            write_go <= 1'b0;
            read_remaining <= '0;
            write_remaining <= '0;
        end else begin
            read_go <= read_launch;
            write_go <= write_launch;
            if (read_launch)
                read_count <= read_chunk;
            if (write_launch)
                write_count <= write_chunk;

            // advance once the go pulse has been seen.
            if (read_go) begin
                read_remaining <= read_remaining - LENGTH_WIDTH'(read_count);
                read_pointer <= read_pointer + 32'(read_count) * 32'(BYTE_LANES);
            end
            if (write_go) begin
                write_remaining <= write_remaining - LENGTH_WIDTH'(write_count);
                write_pointer <= write_pointer + 32'(write_count) * 32'(BYTE_LANES);
            end

            case (state)
                INTAKE_IDLE: begin
                    if (cmd_req) begin
                        op <= cmd_op;
                        read_pointer <= cmd_source;
                        write_pointer <= cmd_destination;
                        read_remaining <= cmd_length;
                        write_remaining <= cmd_length;
                        state <= INTAKE_RUN;
                    end
                end
                INTAKE_RUN: begin
                    if (all_done) begin
                        cmd_ack <= 1'b1;
                        state <= INTAKE_ACK;
                    end
                end
                INTAKE_ACK: begin
                    if (!cmd_req) begin   // host closed the handshake.
                        cmd_ack <= 1'b0;
                        state <= INTAKE_IDLE;
                    end
                end
                default: state <= INTAKE_IDLE;
            endcase
        end
    end

endmodule

// File: src/burst_from_memory.sv
`timescale 1ns/100ps

module burst_from_memory (
    input  logic                                   clock,
    input  logic                                   clock_sreset,
    input  logic                                   go,
    output logic                                   busy,
    input  logic [31:0]                            pointer,
    input  logic [burst_copy_pkg::BURST_WIDTH-1:0] burst_count,
    output logic [31:0]                            m_address,
    output logic [burst_copy_pkg::BYTE_LANES-1:0]  m_byteenable,
    input  logic [burst_copy_pkg::DATA_WIDTH-1:0]  m_readdata,
    output logic [burst_copy_pkg::BURST_WIDTH-1:0] m_burstcount,
    output logic                                   m_read,
    input  logic                                   m_waitrequest,
    input  logic                                   m_readdatavalid,
    output logic                                   data_valid,
    output logic [burst_copy_pkg::DATA_WIDTH-1:0]  data
);
    import burst_copy_pkg::*;

    reader_state_t            state;
    logic [BURST_WIDTH-1:0]   remaining;

    // returned words go straight through.
    assign data_valid = m_readdatavalid;
    assign data = m_readdata;
    assign m_byteenable = '1;

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            state <= READER_IDLE;
            m_read <= 1'b0;
            busy <= 1'b0;
        end else begin
            case (state)
                READER_IDLE: begin
                    m_address <= pointer;
                    m_burstcount <= burst_count;
                    remaining <= burst_count;
                    if (go) begin
                        m_read <= 1'b1;
                        busy <= 1'b1;
                        state <= READER_REQUEST;
                    end
                end
                READER_REQUEST: begin
                    if (!m_waitrequest) begin   // request accepted.
                        m_read <= 1'b0;
                        state <= READER_RECEIVE;
                    end
                end
                READER_RECEIVE: begin
                    if (m_readdatavalid) begin
                        remaining <= remaining - 1'b1;
                        if (remaining == BURST_WIDTH'(1)) begin
                            busy <= 1'b0;
                            state <= READER_IDLE;
                        end
                    end
                end
                default: state <= READER_IDLE;
            endcase
        end
    end

endmodule

// File: src/stream_transform_buffer.sv
`timescale 1ns/100ps

module stream_transform_buffer (
    input  logic                                   clock,
    input  logic                                   clock_sreset,
    input  burst_copy_pkg::copy_op_t               op,
    input  logic                                   word_valid,
    input  logic [burst_copy_pkg::DATA_WIDTH-1:0]  word_data,
    output logic                                   fifo_valid,
    output logic [burst_copy_pkg::DATA_WIDTH-1:0]  fifo_data,
    input  logic                                   fifo_take,
    output logic [burst_copy_pkg::LEVEL_WIDTH-1:0] fifo_level
);
    import burst_copy_pkg::*;

    logic [DATA_WIDTH-1:0]    mem [FIFO_DEPTH];
    logic [LEVEL_WIDTH-2:0]   write_index;
    logic [LEVEL_WIDTH-2:0]   read_index;
    logic [LEVEL_WIDTH-1:0]   stored;
    logic                     stage_valid;
    logic [DATA_WIDTH-1:0]    stage_data;
    logic [DATA_WIDTH-1:0]    transformed;

    always_comb begin
        case (op)
            OP_INVERT:     transformed = ~word_data;
            OP_SWAP_BYTES: transformed = {word_data[DATA_WIDTH/2-1:0],
                                          word_data[DATA_WIDTH-1:DATA_WIDTH/2]};
            default:       transformed = word_data;   // plain copy.
        endcase
    end

    // transform stage.
    always_ff @(posedge clock) begin
        if (clock_sreset)
            stage_valid <= 1'b0;
        else
            stage_valid <= word_valid;
        stage_data <= transformed;
    end

    // circular buffer, depth is a power of two so indexes wrap.
    always_ff @(posedge clock) begin
        if (stage_valid)
            mem[write_index] <= stage_data;
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            write_index <= '0;
            read_index <= '0;
            stored <= '0;
        end else begin
            if (stage_valid)
                write_index <= write_index + 1'b1;
            if (fifo_take)
                read_index <= read_index + 1'b1;
            case ({stage_valid, fifo_take})
                2'b10:   stored <= stored + 1'b1;
                2'b01:   stored <= stored - 1'b1;
                default: stored <= stored;
            endcase
        end
    end

    // show-ahead output.
    assign fifo_valid = (stored != '0);
    assign fifo_data = mem[read_index];

    // word in the stage already holds a slot.
    assign fifo_level = stored + LEVEL_WIDTH'(stage_valid);

endmodule

// File: src/burst_to_memory.sv
`timescale 1ns/100ps

module burst_to_memory (
    input  logic                                   clock,
    input  logic                                   clock_sreset,
    input  logic                                   go,
    output logic                                   busy,
    input  logic [31:0]                            pointer,
    input  logic [burst_copy_pkg::BURST_WIDTH-1:0] burst_count,
    input  logic                                   fifo_valid,
    input  logic [burst_copy_pkg::DATA_WIDTH-1:0]  fifo_data,
    output logic                                   fifo_take,
    output logic [31:0]                            m_address,
    output logic [burst_copy_pkg::BYTE_LANES-1:0]  m_byteenable,
    output logic [burst_copy_pkg::BURST_WIDTH-1:0] m_burstcount,
    output logic                                   m_write,
    output logic [burst_copy_pkg::DATA_WIDTH-1:0]  m_writedata,
    input  logic                                   m_waitrequest
);
    import burst_copy_pkg::*;

    writer_state_t            state;
    logic [BURST_WIDTH-1:0]   remaining;
    logic                     last_beat;

    assign m_byteenable = '1;
    assign m_writedata = fifo_data;

    // write strobe follows the FIFO, a gap in data is a gap in the burst.
    assign m_write = (state == WRITER_BURST) && fifo_valid;
    assign fifo_take = m_write && !m_waitrequest;
    assign last_beat = fifo_take && (remaining == BURST_WIDTH'(1));

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            state <= WRITER_IDLE;
            busy <= 1'b0;
        end else begin
            case (state)
                WRITER_IDLE: begin
                    if (go) begin
                        busy <= 1'b1;
                        state <= WRITER_BURST;
                    end
                end
                WRITER_BURST: begin
                    if (last_beat) begin
                        busy <= 1'b0;
                        state <= WRITER_IDLE;
                    end
                end
                default: state <= WRITER_IDLE;
            endcase
        end
    end

    // address and burst length stay put for the whole burst.
    always_ff @(posedge clock) begin
        if (state == WRITER_IDLE) begin
            if (go) begin
                m_address <= pointer;
                m_burstcount <= burst_count;
                remaining <= burst_count;
            end
        end else if (fifo_take) begin
            remaining <= remaining - 1'b1;   // one beat accepted.
        end
    end

endmodule

// File: src/burst_copy_top.sv
`timescale 1ns/100ps

module burst_copy_top (
    input  logic                                    clock,
    input  logic                                    clock_sreset,
    input  logic                                    cmd_req,
    output logic                                    cmd_ack,
    input  logic [31:0]                             cmd_source,
    input  logic [31:0]                             cmd_destination,
    input  logic [burst_copy_pkg::LENGTH_WIDTH-1:0] cmd_length,
    input  burst_copy_pkg::copy_op_t                cmd_op,
    output logic [31:0]                             rd_address,
    output logic [burst_copy_pkg::BYTE_LANES-1:0]   rd_byteenable,
    output logic [burst_copy_pkg::BURST_WIDTH-1:0]  rd_burstcount,
    output logic                                    rd_read,
    input  logic [burst_copy_pkg::DATA_WIDTH-1:0]   rd_readdata,
    input  logic                                    rd_waitrequest,
    input  logic                                    rd_readdatavalid,
    output logic [31:0]                             wr_address,
    output logic [burst_copy_pkg::BYTE_LANES-1:0]   wr_byteenable,
    output logic [burst_copy_pkg::BURST_WIDTH-1:0]  wr_burstcount,
    output logic                                    wr_write,
    output logic [burst_copy_pkg::DATA_WIDTH-1:0]   wr_writedata,
    input  logic                                    wr_waitrequest
);
    import burst_copy_pkg::*;

    copy_op_t                 op;
    logic                     read_go;
    logic                     read_busy;
    logic [31:0]              read_pointer;
    logic [BURST_WIDTH-1:0]   read_count;
    logic                     write_go;
    logic                     write_busy;
    logic [31:0]              write_pointer;
    logic [BURST_WIDTH-1:0]   write_count;
    logic                     word_valid;
    logic [DATA_WIDTH-1:0]    word_data;
    logic                     fifo_valid;
    logic [DATA_WIDTH-1:0]    fifo_data;
    logic                     fifo_take;
    logic [LEVEL_WIDTH-1:0]   fifo_level;

    copy_command_intake intake (
        .clock, .clock_sreset,
        .cmd_req, .cmd_ack, .cmd_source, .cmd_destination, .cmd_length, .cmd_op,
        .op,
        .read_go, .read_busy, .read_pointer, .read_count,
        .write_go, .write_busy, .write_pointer, .write_count,
        .fifo_level
    );

    burst_from_memory reader (
        .clock, .clock_sreset,
        .go(read_go), .busy(read_busy), .pointer(read_pointer), .burst_count(read_count),
        .m_address(rd_address), .m_byteenable(rd_byteenable), .m_readdata(rd_readdata),
        .m_burstcount(rd_burstcount), .m_read(rd_read), .m_waitrequest(rd_waitrequest),
        .m_readdatavalid(rd_readdatavalid),
        .data_valid(word_valid), .data(word_data)
    );

    stream_transform_buffer buffer (
        .clock, .clock_sreset,
        .op, .word_valid, .word_data,
        .fifo_valid, .fifo_data, .fifo_take, .fifo_level
    );

    burst_to_memory writer (
        .clock, .clock_sreset,
        .go(write_go), .busy(write_busy), .pointer(write_pointer), .burst_count(write_count),
        .fifo_valid, .fifo_data, .fifo_take,
        .m_address(wr_address), .m_byteenable(wr_byteenable), .m_burstcount(wr_burstcount),
        .m_write(wr_write), .m_writedata(wr_writedata), .m_waitrequest(wr_waitrequest)
    );

endmodule

// File: bench/burst_copy_chk.sv
`timescale 1ns/100ps

module burst_copy_chk (
    input  logic                                   clock,
    input  logic                                   clock_sreset,
    input  logic                                   cmd_req,
    input  logic                                   cmd_ack,
    input  logic [burst_copy_pkg::LEVEL_WIDTH-1:0] fifo_level,
    input  logic                                   m_request,
    input  logic                                   m_waitrequest,
    input  logic [31:0]                            m_address,
    input  logic [burst_copy_pkg::BURST_WIDTH-1:0] m_burstcount
);
    import burst_copy_pkg::*;

    ack_needs_req: assert property (@(posedge clock) disable iff (clock_sreset)
        $rose(cmd_ack) |-> cmd_req)
        else $error("cmd_ack rose while cmd_req was low");

    // a stalled request keeps its address and length.
    stalled_request_held: assert property (@(posedge clock) disable iff (clock_sreset)
        (m_request && m_waitrequest) |=>
            (m_request && $stable(m_address) && $stable(m_burstcount)))
        else $error("master request changed while stalled");

    level_in_range: assert property (@(posedge clock) disable iff (clock_sreset)
        fifo_level <= LEVEL_WIDTH'(FIFO_DEPTH))
        else $error("fifo_level above FIFO depth");

endmodule

bind copy_command_intake burst_copy_chk intake_chk (
    .clock, .clock_sreset, .cmd_req, .cmd_ack, .fifo_level,
    .m_request(1'b0), .m_waitrequest(1'b0), .m_address(32'd0), .m_burstcount('0)
);

bind burst_from_memory burst_copy_chk reader_chk (
    .clock, .clock_sreset, .cmd_req(1'b0), .cmd_ack(1'b0), .fifo_level('0),
    .m_request(m_read), .m_waitrequest, .m_address, .m_burstcount
);

bind burst_to_memory burst_copy_chk writer_chk (
    .clock, .clock_sreset, .cmd_req(1'b0), .cmd_ack(1'b0), .fifo_level('0),
    .m_request(m_write), .m_waitrequest, .m_address, .m_burstcount
);

// File: bench/burst_copy_tb.sv
`timescale 1ns/100ps

module burst_copy_tb;
    import burst_copy_pkg::*;

    localparam int MEM_WORDS    = 1024;
    localparam int SOURCE_WORDS = 256;
    localparam int TEST_COUNT   = 4;
    localparam int WORD_CYCLES  = 24;   // per-word cycle bound for the watchdog.
    localparam logic [BYTE_LANES-1:0] ALL_LANES = '1;

    typedef struct packed {
        logic [31:0] source;
        logic [31:0] destination;
        logic [15:0] length;
        copy_op_t    op;
        logic [1:0]  stall;   // write waitrequest weight in quarters.
    } command_t;

    command_t commands [TEST_COUNT] = '{
        '{32'h000, 32'h400, 16'd16, OP_COPY,       2'd1},
        '{32'h040, 32'h500, 16'd13, OP_INVERT,     2'd1},
        '{32'h080, 32'h600, 16'd40, OP_SWAP_BYTES, 2'd3},
        '{32'h100, 32'h700, 16'd0,  OP_COPY,       2'd1}
    };

    logic                    clock = 1'b0;
    logic                    clock_sreset;
    logic                    cmd_req;
    logic                    cmd_ack;
    logic [31:0]             cmd_source;
    logic [31:0]             cmd_destination;
    logic [LENGTH_WIDTH-1:0] cmd_length;
    copy_op_t                cmd_op;
    logic [31:0]             rd_address;
    logic [BYTE_LANES-1:0]   rd_byteenable;
    logic [BURST_WIDTH-1:0]  rd_burstcount;
    logic                    rd_read;
    logic [DATA_WIDTH-1:0]   rd_readdata = '0;
    logic                    rd_waitrequest = 1'b1;
    logic                    rd_readdatavalid = 1'b0;
    logic [31:0]             wr_address;
    logic [BYTE_LANES-1:0]   wr_byteenable;
    logic [BURST_WIDTH-1:0]  wr_burstcount;
    logic                    wr_write;
    logic [DATA_WIDTH-1:0]   wr_writedata;
    logic                    wr_waitrequest = 1'b1;

    logic [DATA_WIDTH-1:0]   mem [MEM_WORDS];
    logic                    memory_ready = 1'b0;
    logic [15:0]             lfsr_state = 16'd54155;
    logic [1:0]              write_stall = 2'd1;
    int                      read_index = 0;
    int                      read_left = 0;
    int                      read_delay = 0;
    int                      write_beat = 0;
    int                      read_words = 0;
    int                      read_bursts = 0;
    int                      write_words = 0;
    int                      checks = 0;
    int                      errors = 0;

    burst_copy_top DUT (.*);

    always #50 clock = ~clock;

    // taps 16, 15, 13, 4.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
    endfunction

    function automatic logic [15:0] random_bits(input int count);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[14:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [15:0] fill_word(input int index);
        return {6'h2A, 10'(index)};
    endfunction

    function automatic logic [15:0] expected_word(input copy_op_t op, input logic [15:0] word);
        case (op)
            OP_INVERT:     return ~word;
            OP_SWAP_BYTES: return {word[7:0], word[15:8]};
            default:       return word;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // memory model for both masters.
    always @(negedge clock) begin
        if (!memory_ready) begin
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] = fill_word(i);
            for (int i = 0; i < SOURCE_WORDS; i++)
                mem[i] = random_bits(16);
            memory_ready = 1'b1;
        end
        rd_readdatavalid = 1'b0;
        if (read_left != 0) begin
            if (read_delay != 0)
                read_delay--;
            else if (random_bits(2) != 2'd0) begin
                rd_readdatavalid = 1'b1;
                rd_readdata = mem[read_index];
                read_index++;
                read_left--;
                read_words++;
            end
        end
        rd_waitrequest = (random_bits(2) == 2'd0);
        if (rd_read && !rd_waitrequest) begin   // accepted at the next rising edge.
            check_value("rd_byteenable", 32'(ALL_LANES), 32'(rd_byteenable));
            read_index = int'(rd_address >> 1);
            read_left = int'(rd_burstcount);
            read_delay = int'(random_bits(2));
            read_bursts++;
        end
        wr_waitrequest = (random_bits(2) < 16'(write_stall));
        if (wr_write && !wr_waitrequest) begin
            check_value("wr_byteenable", 32'(ALL_LANES), 32'(wr_byteenable));
            mem[int'(wr_address >> 1) + write_beat] = wr_writedata;
            write_words++;
            if (write_beat + 1 == int'(wr_burstcount))
                write_beat = 0;
            else
                write_beat++;
        end
    end

    task automatic run_command(input int t);
        int reads_before;
        int bursts_before;
        int writes_before;
        int errors_before;
        int cycles;
        int src;
        int dst;
        int length;
        errors_before = errors;
        src = int'(commands[t].source >> 1);
        dst = int'(commands[t].destination >> 1);
        length = int'(commands[t].length);
        @(posedge clock);
        write_stall = commands[t].stall;
        @(negedge clock);
        reads_before = read_words;
        bursts_before = read_bursts;
        writes_before = write_words;
        cmd_source = commands[t].source;
        cmd_destination = commands[t].destination;
        cmd_length = commands[t].length;
        cmd_op = commands[t].op;
        cmd_req = 1'b1;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!cmd_ack);
        if (length == 0)
            check_value("cmd_ack latency", 32'd2, 32'(cycles));
        check_value("write words at cmd_ack", 32'(length), 32'(write_words - writes_before));
        check_value("read words at cmd_ack", 32'(length), 32'(read_words - reads_before));
        check_value("read bursts", 32'((length + MAX_BURST - 1) / MAX_BURST),
                    32'(read_bursts - bursts_before));
        @(negedge clock);
        check_value("cmd_ack while cmd_req high", 32'd1, 32'(cmd_ack));
        cmd_req = 1'b0;
        cycles = 0;
        while (cmd_ack && cycles < 8) begin
            @(negedge clock);
            cycles++;
        end
        if (cmd_ack) begin
            errors++;
            $display("test %0d: cmd_ack stayed high after cmd_req fell", t);
        end
        for (int j = 0; j < length; j++)
            check_value($sformatf("mem[%0d]", dst + j),
                        32'(expected_word(commands[t].op, mem[src + j])), 32'(mem[dst + j]));
        check_value($sformatf("mem[%0d]", dst - 1), 32'(fill_word(dst - 1)), 32'(mem[dst - 1]));
        check_value($sformatf("mem[%0d]", dst + length), 32'(fill_word(dst + length)),
                    32'(mem[dst + length]));
        $display("test %0d: %s length %0d, %0d errors", t, commands[t].op.name(), length,
                 errors - errors_before);
    endtask

    initial begin
        clock_sreset = 1'b1;
        cmd_req = 1'b0;
        cmd_source = '0;
        cmd_destination = '0;
        cmd_length = '0;
        cmd_op = OP_COPY;
        repeat (5) @(posedge clock);
        @(negedge clock);
        clock_sreset = 1'b0;
        for (int t = 0; t < TEST_COUNT; t++)
            run_command(t);
        $display("tests %0d, checks %0d, errors %0d", TEST_COUNT, checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // watchdog.
    initial begin
        int limit_cycles;
        limit_cycles = 200;
        for (int t = 0; t < TEST_COUNT; t++)
            limit_cycles += int'(commands[t].length) * WORD_CYCLES + 50;
        repeat (limit_cycles) @(posedge clock);
        $display("watchdog: no finish after %0d cycles, a command did not complete",
                 limit_cycles);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: all.f
src/burst_copy_pkg.sv
src/copy_command_intake.sv
src/burst_from_memory.sv
src/stream_transform_buffer.sv
src/burst_to_memory.sv
src/burst_copy_top.sv
bench/burst_copy_chk.sv
bench/burst_copy_tb.sv

// File: Makefile
VERILATOR       ?= verilator
TOP             ?= burst_copy_tb
FILE_LIST       ?= all.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
FAIL_TEXT       ?= Regression failed
PASS_TEXT       ?= Regression passed
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "check: the log reports a failure"; exit 1; \
	elif ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "check: the run ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
